// File: include/cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Instruction word and control field widths
`define CU_DATA_W 8
`define CU_WEN_W  13
`define CU_BUS_W  5
`define CU_INC_W  6
`define CU_RST_W  5
`define CU_CMP_W  3
`define CU_ALU_W  4

// Register write mask
`define CU_WEN_PC  12
`define CU_WEN_IR  11
`define CU_WEN_AR  10
`define CU_WEN_DR  9
`define CU_WEN_RP  8
`define CU_WEN_RT  7
`define CU_WEN_RM1 6
`define CU_WEN_RK1 5
`define CU_WEN_RN1 4
`define CU_WEN_C1  3
`define CU_WEN_C2  2
`define CU_WEN_C3  1
`define CU_WEN_AC  0

// Increment mask
`define CU_INC_PC 5
`define CU_INC_M2 4
`define CU_INC_K2 3
`define CU_INC_N2 2
`define CU_INC_C2 1
`define CU_INC_C3 0

// Reset mask
`define CU_RST_RT 4
`define CU_RST_M2 3
`define CU_RST_K2 2
`define CU_RST_N2 1
`define CU_RST_AC 0

// Comparator pair select, one-hot
`define CU_CMP_M 2
`define CU_CMP_K 1
`define CU_CMP_N 0

// ALU operations, one-hot
`define CU_ALU_SET    4'b0001
`define CU_ALU_MUL    4'b0010
`define CU_ALU_ADD    4'b0100
`define CU_ALU_ADDMEM 4'b1000

// Bus source codes, zero means nothing driven
`define CU_BUS_AC  5'd1
`define CU_BUS_C3  5'd2
`define CU_BUS_C2  5'd3
`define CU_BUS_C1  5'd4
`define CU_BUS_RN2 5'd5
`define CU_BUS_RK2 5'd6
`define CU_BUS_RM2 5'd7
`define CU_BUS_RN1 5'd8
`define CU_BUS_RK1 5'd9
`define CU_BUS_RM1 5'd10
`define CU_BUS_RT  5'd11
`define CU_BUS_RP  5'd12
`define CU_BUS_DR  5'd13
`define CU_BUS_AR  5'd14
`define CU_BUS_MEM 5'd15

`endif

// File: hdl/cuPkg.sv
package cuPkg;

    // Opcode group in ins[7:4]
    typedef enum logic [3:0] {
        OP_JMP,
        OP_COPY,
        OP_LOAD,
        OP_STORE,
        OP_ASSIGN,
        OP_RESET,
        OP_MOVE,
        OP_SET,
        OP_MUL,
        OP_ADD,
        OP_INC,
        OP_END,
        OP_CHK_IDLE
    } opGroupT;

    // Variants in ins[3:0], one set per group
    typedef enum logic [3:0] {JMP_M, JMP_K, JMP_N} jmpVarT;
    typedef enum logic [3:0] {COPY_M, COPY_K, COPY_N} copyVarT;
    typedef enum logic [3:0] {LOAD_C1, LOAD_C2} loadVarT;
    typedef enum logic [3:0] {ASSIGN_C1, ASSIGN_C2} assignVarT;
    typedef enum logic [3:0] {RESET_ALL, RESET_N2, RESET_K2, RESET_RT} resetVarT;
    typedef enum logic [3:0] {MOVE_RP, MOVE_RT, MOVE_C1, MOVE_C3} moveVarT;
    typedef enum logic [3:0] {SET_C1, SET_DR} setVarT;
    typedef enum logic [3:0] {MUL_RP} mulVarT;
    typedef enum logic [3:0] {ADD_RT, ADD_M2, ADD_MEM} addVarT;
    typedef enum logic [3:0] {INC_C2, INC_C3, INC_M2, INC_K2, INC_N2} incVarT;

    // Micro-states, FETCH_1 first so it is the reset encoding
    typedef enum logic [5:0] {
        FETCH_1, FETCH_2, FETCH_3,
        JMPM_1, JMPK_1, JMPN_1, ZJMP_1,
        JMP_2, JMP_3, JMP_4, NJMP_1,
        COPY_1, COPY_2, COPYM_3A, COPY_3, COPY_4,
        COPYM_5, COPYK_5, COPYN_5,
        LOADC1_1, LOADC2_1, LOAD_2, LOAD_3,
        STORE_1, STORE_2, STORE_3,
        ASSIGN_1, ASSIGN_2, ASSIGNC1_3A, ASSIGNC1_3, ASSIGNC2_3,
        RESETALL_1, RESETN2_1, RESETK2_1, RESETRT_1,
        MOVEP_1, MOVET_1, MOVEC1_1, MOVEC3_1,
        SETC1_1, SETDR_1,
        MULRP_1,
        ADDRT_1, ADDRM2_1, ADDC3_1,
        INCC2_1, INCC3_1, INCM2_1, INCK2_1, INCN2_1,
        ENDOP_1,
        CHKIDLE_1, CHKIDLE_2,
        HOLD_1
    } stateT;

endpackage

// File: hdl/opcodeDecoder.sv
`include "cu_consts.svh"

module opcodeDecoder (
    input  logic [`CU_DATA_W-1:0] ins,
    output cuPkg::stateT          dispatchState,
    output cuPkg::stateT          copyAddrState,
    output cuPkg::stateT          copyDestState,
    output cuPkg::stateT          assignState,
    output cuPkg::stateT          holdExitState
);

    cuPkg::opGroupT group;
    logic [3:0]     variant;

    assign group   = cuPkg::opGroupT'(ins[`CU_DATA_W-1 -: 4]);
    assign variant = ins[3:0];

    // First execute state after FETCH_3
    always_comb begin
        dispatchState = cuPkg::FETCH_1;           // Illegal pair falls back to fetch
        case (group)
            cuPkg::OP_JMP: begin
                case (variant)
                    cuPkg::JMP_M: dispatchState = cuPkg::JMPM_1;
                    cuPkg::JMP_K: dispatchState = cuPkg::JMPK_1;
                    cuPkg::JMP_N: dispatchState = cuPkg::JMPN_1;
                    default:      dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_COPY: begin
                if (variant <= cuPkg::COPY_N)
                    dispatchState = cuPkg::COPY_1;
            end
            cuPkg::OP_LOAD: begin
                case (variant)
                    cuPkg::LOAD_C1: dispatchState = cuPkg::LOADC1_1;
                    cuPkg::LOAD_C2: dispatchState = cuPkg::LOADC2_1;
                    default:        dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_STORE:    dispatchState = cuPkg::STORE_1;   // Any variant
            cuPkg::OP_ASSIGN: begin
                if (variant <= cuPkg::ASSIGN_C2)
                    dispatchState = cuPkg::ASSIGN_1;
            end
            cuPkg::OP_RESET: begin
                case (variant)
                    cuPkg::RESET_ALL: dispatchState = cuPkg::RESETALL_1;
                    cuPkg::RESET_N2:  dispatchState = cuPkg::RESETN2_1;
                    cuPkg::RESET_K2:  dispatchState = cuPkg::RESETK2_1;
                    cuPkg::RESET_RT:  dispatchState = cuPkg::RESETRT_1;
                    default:          dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_MOVE: begin
                case (variant)
                    cuPkg::MOVE_RP: dispatchState = cuPkg::MOVEP_1;
                    cuPkg::MOVE_RT: dispatchState = cuPkg::MOVET_1;
                    cuPkg::MOVE_C1: dispatchState = cuPkg::MOVEC1_1;
                    cuPkg::MOVE_C3: dispatchState = cuPkg::MOVEC3_1;
                    default:        dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_SET: begin
                case (variant)
                    cuPkg::SET_C1: dispatchState = cuPkg::SETC1_1;
                    cuPkg::SET_DR: dispatchState = cuPkg::SETDR_1;
                    default:       dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_MUL: begin
                if (variant == cuPkg::MUL_RP)
                    dispatchState = cuPkg::MULRP_1;
            end
            cuPkg::OP_ADD: begin
                case (variant)
                    cuPkg::ADD_RT:  dispatchState = cuPkg::ADDRT_1;
                    cuPkg::ADD_M2:  dispatchState = cuPkg::ADDRM2_1;
                    cuPkg::ADD_MEM: dispatchState = cuPkg::ADDC3_1;
                    default:        dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_INC: begin
                case (variant)
                    cuPkg::INC_C2: dispatchState = cuPkg::INCC2_1;
                    cuPkg::INC_C3: dispatchState = cuPkg::INCC3_1;
                    cuPkg::INC_M2: dispatchState = cuPkg::INCM2_1;
                    cuPkg::INC_K2: dispatchState = cuPkg::INCK2_1;
                    cuPkg::INC_N2: dispatchState = cuPkg::INCN2_1;
                    default:       dispatchState = cuPkg::FETCH_1;
                endcase
            end
            cuPkg::OP_END:      dispatchState = cuPkg::ENDOP_1;
            cuPkg::OP_CHK_IDLE: dispatchState = cuPkg::CHKIDLE_1;
            default:            dispatchState = cuPkg::FETCH_1;
        endcase
    end

    // Branches inside COPY and ASSIGN
    always_comb begin
        copyAddrState = (variant == cuPkg::COPY_M) ? cuPkg::COPYM_3A : cuPkg::COPY_3;
        case (variant)
            cuPkg::COPY_M: copyDestState = cuPkg::COPYM_5;
            cuPkg::COPY_K: copyDestState = cuPkg::COPYK_5;
            cuPkg::COPY_N: copyDestState = cuPkg::COPYN_5;
            default:       copyDestState = cuPkg::FETCH_1;
        endcase
        case (variant)
            cuPkg::ASSIGN_C1: assignState = cuPkg::ASSIGNC1_3A;
            cuPkg::ASSIGN_C2: assignState = cuPkg::ASSIGNC2_3;
            default:          assignState = cuPkg::FETCH_1;
        endcase
    end

    // Where a finished memory wait resumes
    always_comb begin
        case (group)
            cuPkg::OP_COPY:  holdExitState = cuPkg::COPY_4;
            cuPkg::OP_LOAD:  holdExitState = cuPkg::LOAD_3;
            cuPkg::OP_STORE: holdExitState = cuPkg::FETCH_1;    // Write done, next fetch
            default:         holdExitState = cuPkg::FETCH_1;
        endcase
    end

endmodule

// File: hdl/flagSampler.sv
module flagSampler (
    input  logic         Clk,
    input  logic         arstN,
    input  logic         z,
    input  logic         memAv,
    input  cuPkg::stateT state,
    output logic         zSeen,
    output logic         memReady,
    output logic         loopM
);

    // Comparator result and memory status, one cycle late
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            zSeen    <= 1'b0;
            memReady <= 1'b0;
        end else begin
            zSeen    <= z;
            memReady <= memAv;
        end
    end

    // Marks a compare on the M pair, which is the outer loop.
    // A zero there means the whole program is done.
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            loopM <= 1'b0;
        end else if (state == cuPkg::JMPM_1) begin
            loopM <= 1'b1;
        end else if (state == cuPkg::ZJMP_1) begin
            loopM <= 1'b0;                        // ZJMP_1 lasts one cycle
        end
    end

endmodule

// File: hdl/stateSequencer.sv
module stateSequencer (
    input  logic         Clk,
    input  logic         arstN,
    input  logic         imemAv,
    input  logic         zSeen,
    input  logic         memReady,
    input  logic         loopM,
    input  cuPkg::stateT dispatchState,
    input  cuPkg::stateT copyAddrState,
    input  cuPkg::stateT copyDestState,
    input  cuPkg::stateT assignState,
    input  cuPkg::stateT holdExitState,
    output cuPkg::stateT state
);

    cuPkg::stateT nextState;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= cuPkg::FETCH_1;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            // Fetch
            cuPkg::FETCH_1: nextState = imemAv ? cuPkg::FETCH_2 : cuPkg::FETCH_1;
            cuPkg::FETCH_2: nextState = cuPkg::FETCH_3;
            cuPkg::FETCH_3: nextState = dispatchState;

            // Loop compare and jump
            cuPkg::JMPM_1,
            cuPkg::JMPK_1,
            cuPkg::JMPN_1:  nextState = cuPkg::ZJMP_1;
            cuPkg::ZJMP_1: begin
                if (zSeen && loopM)
                    nextState = cuPkg::ENDOP_1;   // Outer loop exhausted
                else if (zSeen)
                    nextState = cuPkg::NJMP_1;    // Inner loop done, skip target word
                else
                    nextState = cuPkg::JMP_2;
            end
            cuPkg::JMP_2:   nextState = cuPkg::JMP_3;
            cuPkg::JMP_3:   nextState = cuPkg::JMP_4;

            // COPY
            cuPkg::COPY_1:   nextState = cuPkg::COPY_2;
            cuPkg::COPY_2:   nextState = copyAddrState;
            cuPkg::COPYM_3A: nextState = cuPkg::COPY_3;
            cuPkg::COPY_3:   nextState = memReady ? cuPkg::COPY_4 : cuPkg::HOLD_1;
            cuPkg::COPY_4:   nextState = copyDestState;

            // LOAD and STORE
            cuPkg::LOADC1_1,
            cuPkg::LOADC2_1: nextState = cuPkg::LOAD_2;
            cuPkg::LOAD_2:   nextState = memReady ? cuPkg::LOAD_3 : cuPkg::HOLD_1;
            cuPkg::STORE_1:  nextState = cuPkg::STORE_2;
            cuPkg::STORE_2:  nextState = cuPkg::STORE_3;
            cuPkg::STORE_3:  nextState = memReady ? cuPkg::FETCH_1 : cuPkg::HOLD_1;

            // ASSIGN
            cuPkg::ASSIGN_1:    nextState = cuPkg::ASSIGN_2;
            cuPkg::ASSIGN_2:    nextState = assignState;
            cuPkg::ASSIGNC1_3A: nextState = cuPkg::ASSIGNC1_3;

            // Idle check on the M pair
            cuPkg::CHKIDLE_1: nextState = cuPkg::CHKIDLE_2;
            cuPkg::CHKIDLE_2: nextState = zSeen ? cuPkg::ENDOP_1 : cuPkg::FETCH_1;

            cuPkg::ENDOP_1: nextState = cuPkg::ENDOP_1;   // Only reset leaves
            cuPkg::HOLD_1:  nextState = memReady ? holdExitState : cuPkg::HOLD_1;

            // Register execute states and chain ends
            default: nextState = cuPkg::FETCH_1;
        endcase
    end

endmodule

// File: hdl/controlWordGen.sv
`include "cu_consts.svh"

module controlWordGen (
    input  cuPkg::stateT         state,
    output logic                 iRomRead,
    output logic                 memRead,
    output logic                 memWrite,
    output logic [`CU_WEN_W-1:0] wEn,
    output logic                 selAr,
    output logic                 coreIncAr,
    output logic [`CU_BUS_W-1:0] busSel,
    output logic [`CU_INC_W-1:0] inc,
    output logic [`CU_RST_W-1:0] rst,
    output logic [`CU_CMP_W-1:0] compSel,
    output logic [`CU_ALU_W-1:0] aluOp,
    output logic                 coreDone
);

    always_comb begin
        iRomRead  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        wEn       = '0;
        selAr     = 1'b0;
        coreIncAr = 1'b0;
        busSel    = '0;
        inc       = '0;
        rst       = '0;
        compSel   = '0;
        aluOp     = '0;
        coreDone  = 1'b0;
        case (state)
            cuPkg::FETCH_1,
            cuPkg::JMP_2,
            cuPkg::COPY_1,
            cuPkg::ASSIGN_1: iRomRead = 1'b1;        // Wait for the ROM word
            cuPkg::FETCH_2: begin
                wEn[`CU_WEN_IR] = 1'b1;
                inc[`CU_INC_PC] = 1'b1;
            end
            cuPkg::JMPM_1,
            cuPkg::CHKIDLE_1: compSel[`CU_CMP_M] = 1'b1;
            cuPkg::JMPK_1:    compSel[`CU_CMP_K] = 1'b1;
            cuPkg::JMPN_1:    compSel[`CU_CMP_N] = 1'b1;
            cuPkg::JMP_3: begin                      // AR from the ROM word
                wEn[`CU_WEN_AR] = 1'b1;
                selAr           = 1'b1;
            end
            cuPkg::JMP_4: begin
                wEn[`CU_WEN_PC] = 1'b1;
                busSel          = `CU_BUS_AR;
            end
            cuPkg::NJMP_1: inc[`CU_INC_PC] = 1'b1;
            cuPkg::COPY_2,
            cuPkg::ASSIGN_2: begin                   // Address word into AR, past it
                wEn[`CU_WEN_AR] = 1'b1;
                selAr           = 1'b1;
                inc[`CU_INC_PC] = 1'b1;
            end
            cuPkg::COPYM_3A,
            cuPkg::ASSIGNC1_3A: coreIncAr = 1'b1;    // Offset by core ID
            cuPkg::COPY_3,
            cuPkg::LOAD_2: begin
                memRead = 1'b1;
                busSel  = `CU_BUS_MEM;
            end
            cuPkg::COPY_4,
            cuPkg::LOAD_3: begin
                wEn[`CU_WEN_DR] = 1'b1;
                busSel          = `CU_BUS_MEM;
            end
            cuPkg::COPYM_5: begin wEn[`CU_WEN_RM1] = 1'b1; busSel = `CU_BUS_DR; end
            cuPkg::COPYK_5: begin wEn[`CU_WEN_RK1] = 1'b1; busSel = `CU_BUS_DR; end
            cuPkg::COPYN_5: begin wEn[`CU_WEN_RN1] = 1'b1; busSel = `CU_BUS_DR; end
            cuPkg::LOADC1_1: begin wEn[`CU_WEN_AR] = 1'b1; busSel = `CU_BUS_C1; end
            cuPkg::LOADC2_1: begin wEn[`CU_WEN_AR] = 1'b1; busSel = `CU_BUS_C2; end
            cuPkg::STORE_1:  begin wEn[`CU_WEN_DR] = 1'b1; busSel = `CU_BUS_RT; end
            cuPkg::STORE_2:  begin wEn[`CU_WEN_AR] = 1'b1; busSel = `CU_BUS_C3; end
            cuPkg::STORE_3: begin
                memWrite = 1'b1;
                busSel   = `CU_BUS_DR;
            end
            cuPkg::ASSIGNC1_3: begin wEn[`CU_WEN_C1] = 1'b1; busSel = `CU_BUS_AR; end
            cuPkg::ASSIGNC2_3: begin wEn[`CU_WEN_C2] = 1'b1; busSel = `CU_BUS_AR; end
            cuPkg::RESETALL_1: rst = '1;
            cuPkg::RESETN2_1:  rst[`CU_RST_N2] = 1'b1;
            cuPkg::RESETK2_1:  rst[`CU_RST_K2] = 1'b1;
            cuPkg::RESETRT_1:  rst[`CU_RST_RT] = 1'b1;
            // Moves take the accumulator
            cuPkg::MOVEP_1:  begin wEn[`CU_WEN_RP] = 1'b1; busSel = `CU_BUS_AC; end
            cuPkg::MOVET_1:  begin wEn[`CU_WEN_RT] = 1'b1; busSel = `CU_BUS_AC; end
            cuPkg::MOVEC1_1: begin wEn[`CU_WEN_C1] = 1'b1; busSel = `CU_BUS_AC; end
            cuPkg::MOVEC3_1: begin wEn[`CU_WEN_C3] = 1'b1; busSel = `CU_BUS_AC; end
            cuPkg::SETC1_1,
            cuPkg::SETDR_1: begin
                wEn[`CU_WEN_AC] = 1'b1;
                busSel          = (state == cuPkg::SETC1_1) ? `CU_BUS_C1 : `CU_BUS_DR;
                aluOp           = `CU_ALU_SET;
            end
            cuPkg::MULRP_1: begin
                wEn[`CU_WEN_AC] = 1'b1;
                busSel          = `CU_BUS_RP;
                aluOp           = `CU_ALU_MUL;
            end
            cuPkg::ADDRT_1:  begin wEn[`CU_WEN_AC] = 1'b1; busSel = `CU_BUS_RT;  aluOp = `CU_ALU_ADD; end
            cuPkg::ADDRM2_1: begin wEn[`CU_WEN_AC] = 1'b1; busSel = `CU_BUS_RM2; aluOp = `CU_ALU_ADD; end
            cuPkg::ADDC3_1: begin                    // C3 plus AC as an address
                wEn[`CU_WEN_AC] = 1'b1;
                busSel          = `CU_BUS_C3;
                aluOp           = `CU_ALU_ADDMEM;
            end
            cuPkg::INCC2_1: inc[`CU_INC_C2] = 1'b1;
            cuPkg::INCC3_1: inc[`CU_INC_C3] = 1'b1;
            cuPkg::INCM2_1: inc[`CU_INC_M2] = 1'b1;
            cuPkg::INCK2_1: inc[`CU_INC_K2] = 1'b1;
            cuPkg::INCN2_1: inc[`CU_INC_N2] = 1'b1;
            cuPkg::ENDOP_1: coreDone = 1'b1;
            default: ;                               // FETCH_3, ZJMP_1, CHKIDLE_2, HOLD_1
        endcase
    end

endmodule

// File: hdl/controlUnit.sv
`include "cu_consts.svh"

module controlUnit (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  z,
    input  logic [`CU_DATA_W-1:0] ins,
    input  logic                  memAv,
    input  logic                  imemAv,
    output logic                  iRomRead,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [`CU_WEN_W-1:0]  wEn,
    output logic                  selAr,
    output logic                  coreIncAr,
    output logic [`CU_BUS_W-1:0]  busSel,
    output logic [`CU_INC_W-1:0]  inc,
    output logic [`CU_RST_W-1:0]  rst,
    output logic [`CU_CMP_W-1:0]  compSel,
    output logic [`CU_ALU_W-1:0]  aluOp,
    output logic                  coreDone
);

    cuPkg::stateT state;
    cuPkg::stateT dispatchState;
    cuPkg::stateT copyAddrState;
    cuPkg::stateT copyDestState;
    cuPkg::stateT assignState;
    cuPkg::stateT holdExitState;
    logic         zSeen;
    logic         memReady;
    logic         loopM;

    opcodeDecoder u_opcodeDecoder (
        .ins           (ins),
        .dispatchState (dispatchState),
        .copyAddrState (copyAddrState),
        .copyDestState (copyDestState),
        .assignState   (assignState),
        .holdExitState (holdExitState)
    );

    flagSampler u_flagSampler (
        .Clk      (Clk),
        .arstN    (arstN),
        .z        (z),
        .memAv    (memAv),
        .state    (state),
        .zSeen    (zSeen),
        .memReady (memReady),
        .loopM    (loopM)
    );

    stateSequencer u_stateSequencer (
        .Clk           (Clk),
        .arstN         (arstN),
        .imemAv        (imemAv),
        .zSeen         (zSeen),
        .memReady      (memReady),
        .loopM         (loopM),
        .dispatchState (dispatchState),
        .copyAddrState (copyAddrState),
        .copyDestState (copyDestState),
        .assignState   (assignState),
        .holdExitState (holdExitState),
        .state         (state)
    );

    controlWordGen u_controlWordGen (
        .state     (state),
        .iRomRead  (iRomRead),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .wEn       (wEn),
        .selAr     (selAr),
        .coreIncAr (coreIncAr),
        .busSel    (busSel),
        .inc       (inc),
        .rst       (rst),
        .compSel   (compSel),
        .aluOp     (aluOp),
        .coreDone  (coreDone)
    );

endmodule

// File: tb/clockGen.sv
module clockGen (
    output logic Clk,
    output logic arstN
);

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;                 // Period 20
    end

    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge Clk);
        arstN <= 1'b1;                          // Released after three cycles
    end

endmodule

// File: tb/controlUnitTb.sv
`include "cu_consts.svh"

module controlUnitTb;

    logic                 Clk;
    logic                 arstN;
    logic                 z;
    logic [`CU_DATA_W-1:0] ins;
    logic                 memAv;
    logic                 imemAv;
    logic                 iRomRead;
    logic                 memRead;
    logic                 memWrite;
    logic [`CU_WEN_W-1:0] wEn;
    logic                 selAr;
    logic                 coreIncAr;
    logic [`CU_BUS_W-1:0] busSel;
    logic [`CU_INC_W-1:0] inc;
    logic [`CU_RST_W-1:0] rst;
    logic [`CU_CMP_W-1:0] compSel;
    logic [`CU_ALU_W-1:0] aluOp;
    logic                 coreDone;

    // Monitor bookkeeping
    int          cycle = 0;
    int          irCycle = -100;
    int          incCount = 0;
    logic [7:0]  decIns = '0;
    logic        decZ = 1'b0;
    logic        arstPrev = 1'b0;
    logic        memOpen = 1'b0;
    logic        memAvSeen = 1'b0;
    logic        doneLatched = 1'b0;
    logic        finalIssued = 1'b0;
    logic        obsIrWrite = 1'b0;
    logic        obsMemAccess = 1'b0;
    logic        obsMemClose = 1'b0;

    // Stimulus bookkeeping
    logic        memPending = 1'b0;
    int          memDelay = 0;

    logic [41:0] ctrlWord;
    assign ctrlWord = {iRomRead, memRead, memWrite, wEn, selAr, coreIncAr,
                       busSel, inc, rst, compSel, aluOp, coreDone};

    clockGen u_clockGen (
        .Clk   (Clk),
        .arstN (arstN)
    );

    controlUnit u_controlUnit (
        .Clk       (Clk),
        .arstN     (arstN),
        .z         (z),
        .ins       (ins),
        .memAv     (memAv),
        .imemAv    (imemAv),
        .iRomRead  (iRomRead),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .wEn       (wEn),
        .selAr     (selAr),
        .coreIncAr (coreIncAr),
        .busSel    (busSel),
        .inc       (inc),
        .rst       (rst),
        .compSel   (compSel),
        .aluOp     (aluOp),
        .coreDone  (coreDone)
    );

    task automatic reportMismatch(input string sig, input logic [63:0] expVal,
                                  input logic [63:0] gotVal);
        $display("Fail time %0t signal %s expected %0h got %0h", $time, sig, expVal, gotVal);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic reportProblem(input string what);
        $display("Error at time %0t: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic int variantCount(input logic [3:0] grp);
        case (grp)
            4'd0, 4'd1, 4'd9: variantCount = 3;  // JMP, COPY, ADD
            4'd2, 4'd4, 4'd7: variantCount = 2;  // LOAD, ASSIGN, SET
            4'd5, 4'd6:       variantCount = 4;  // RESET, MOVE
            4'd10:            variantCount = 5;  // INC
            default:          variantCount = 1;
        endcase
    endfunction

    function automatic logic isRegisterIns(input logic [7:0] insVal);
        isRegisterIns = (insVal[7:4] >= 4'd5) && (insVal[7:4] <= 4'd10);
    endfunction

    // Expected execute-state word of a register instruction
    function automatic logic [41:0] expWord(input logic [7:0] insVal);
        logic [`CU_WEN_W-1:0] w;
        logic [`CU_BUS_W-1:0] b;
        logic [`CU_INC_W-1:0] i;
        logic [`CU_RST_W-1:0] r;
        logic [`CU_ALU_W-1:0] a;
        logic [3:0]           v;
        w = '0;
        b = '0;
        i = '0;
        r = '0;
        a = '0;
        v = insVal[3:0];
        case (insVal[7:4])
            4'd5: begin                                   // RESET
                case (v)
                    4'd0: r = '1;
                    4'd1: r[`CU_RST_N2] = 1'b1;
                    4'd2: r[`CU_RST_K2] = 1'b1;
                    default: r[`CU_RST_RT] = 1'b1;
                endcase
            end
            4'd6: begin                                   // MOVE from AC
                b = `CU_BUS_AC;
                case (v)
                    4'd0: w[`CU_WEN_RP] = 1'b1;
                    4'd1: w[`CU_WEN_RT] = 1'b1;
                    4'd2: w[`CU_WEN_C1] = 1'b1;
                    default: w[`CU_WEN_C3] = 1'b1;
                endcase
            end
            4'd7: begin
                w[`CU_WEN_AC] = 1'b1;
                a = `CU_ALU_SET;
                b = (v == 4'd0) ? `CU_BUS_C1 : `CU_BUS_DR;
            end
            4'd8: begin
                w[`CU_WEN_AC] = 1'b1;
                a = `CU_ALU_MUL;
                b = `CU_BUS_RP;
            end
            4'd9: begin
                w[`CU_WEN_AC] = 1'b1;
                case (v)
                    4'd0: begin
                        b = `CU_BUS_RT;
                        a = `CU_ALU_ADD;
                    end
                    4'd1: begin
                        b = `CU_BUS_RM2;
                        a = `CU_ALU_ADD;
                    end
                    default: begin
                        b = `CU_BUS_C3;
                        a = `CU_ALU_ADDMEM;
                    end
                endcase
            end
            default: begin                                // INC
                case (v)
                    4'd0: i[`CU_INC_C2] = 1'b1;
                    4'd1: i[`CU_INC_C3] = 1'b1;
                    4'd2: i[`CU_INC_M2] = 1'b1;
                    4'd3: i[`CU_INC_K2] = 1'b1;
                    default: i[`CU_INC_N2] = 1'b1;
                endcase
            end
        endcase
        expWord = {3'b000, w, 2'b00, b, i, r, 3'b000, a, 1'b0};
    endfunction

    // Checks on stable outputs half a cycle after each edge
    always @(negedge Clk) begin
        cycle = cycle + 1;
        if (!arstN || !arstPrev) begin
            assert (ctrlWord == {1'b1, 41'b0})
                else reportMismatch("reset control word", {1'b1, 41'b0}, ctrlWord);
        end
        arstPrev = arstN;
        if (arstN) begin
            assert (!(memRead && memWrite))
                else reportProblem("memRead and memWrite are high together");
            if (memRead || memWrite) begin
                if (!memOpen)
                    memAvSeen = 1'b0;
                memOpen = 1'b1;
            end
            if (memOpen && memAv)
                memAvSeen = 1'b1;
            obsMemClose = 1'b0;
            if (memOpen && ((wEn[`CU_WEN_DR] && busSel == `CU_BUS_MEM) || wEn[`CU_WEN_IR])) begin
                assert (memAvSeen)
                    else reportProblem("memory access finished before memAv was seen high");
                memOpen = 1'b0;
                obsMemClose = 1'b1;
            end
            obsMemAccess = memRead || memWrite;
            obsIrWrite = wEn[`CU_WEN_IR];

            if (coreIncAr)
                incCount = incCount + 1;
            if (wEn[`CU_WEN_IR]) begin
                int expInc;
                expInc = (decIns == 8'h10 || decIns == 8'h40) ? 1 : 0;
                assert (incCount == expInc)
                    else reportMismatch("coreIncAr pulses", expInc, incCount);
                incCount = 0;
                irCycle = cycle;
            end
            if (cycle == irCycle + 1) begin           // ins now holds the new word
                decIns = ins;
                decZ = z;
            end
            if (cycle == irCycle + 2 && isRegisterIns(decIns)) begin
                assert (ctrlWord == expWord(decIns))
                    else reportMismatch("control word", expWord(decIns), ctrlWord);
            end
            if (decIns[7:4] == 4'd0 && decIns[3:0] <= 4'd2) begin
                if (!decZ && cycle == irCycle + 6) begin
                    assert (wEn[`CU_WEN_PC])
                        else reportMismatch("wEn", 1 << `CU_WEN_PC, wEn);
                    assert (busSel == `CU_BUS_AR)
                        else reportMismatch("busSel", `CU_BUS_AR, busSel);
                end
                if (decZ && decIns[3:0] != 4'd0 && cycle == irCycle + 4) begin
                    assert (inc[`CU_INC_PC])
                        else reportMismatch("inc", 1 << `CU_INC_PC, inc);
                end
            end

            assert (!coreDone || finalIssued)
                else reportProblem("coreDone rose before the final jump");
            if (coreDone)
                doneLatched = 1'b1;
            if (doneLatched) begin
                assert (ctrlWord == 42'd1)
                    else reportMismatch("done control word", 42'd1, ctrlWord);
            end
        end
    end

    // Instruction ROM and data memory availability
    task automatic driveBackground();
        imemAv <= ($urandom % 4) != 0;
        if (obsMemClose) begin
            memPending = 1'b0;
            memAv <= 1'b0;
        end else if (obsMemAccess && !memPending) begin
            memPending = 1'b1;
            memDelay = $urandom % 5;
        end
        if (memPending) begin
            if (memDelay == 0)
                memAv <= 1'b1;
            else
                memDelay = memDelay - 1;
        end
    endtask

    initial begin
        int         seedVal;
        int         waitCycles;
        int         numIns;
        logic [3:0] grp;
        logic [3:0] vnt;
        logic [7:0] nextIns;
        logic       nextZ;
        logic       loaded;
        ins    = '0;
        z      = 1'b0;
        memAv  = 1'b0;
        imemAv = 1'b0;
        seedVal = $urandom(88370);
        numIns = 60;

        waitCycles = 0;
        while (arstN !== 1'b1) begin
            @(posedge Clk);
            waitCycles = waitCycles + 1;
            if (waitCycles > 20)
                reportProblem("reset was never released");
        end

        for (int n = 0; n <= numIns; n++) begin
            if (n == numIns) begin
                nextIns = 8'h00;                  // Final JMP_M with the zero flag up
                nextZ = 1'b1;
            end else begin
                grp = 4'($urandom % 12);
                if (grp == 4'd11)
                    grp = 4'd12;                  // CHK_IDLE in place of END
                vnt = 4'($urandom % variantCount(grp));
                nextIns = {grp, vnt};
                nextZ = 1'($urandom % 2);
                if (nextIns == 8'h00 || grp == 4'd12)
                    nextZ = 1'b0;                 // Keep the program running
            end
            loaded = 1'b0;
            waitCycles = 0;
            while (!loaded) begin
                @(posedge Clk);
                driveBackground();
                if (obsIrWrite) begin
                    ins <= nextIns;
                    z   <= nextZ;
                    if (n == numIns)
                        finalIssued = 1'b1;
                    loaded = 1'b1;
                end
                waitCycles = waitCycles + 1;
                if (waitCycles > 300)
                    reportProblem("instruction register write never came");
            end
        end

        waitCycles = 0;
        while (!doneLatched) begin
            @(posedge Clk);
            driveBackground();
            waitCycles = waitCycles + 1;
            if (waitCycles > 50)
                reportProblem("coreDone never rose after the final jump");
        end
        repeat (10) begin
            @(posedge Clk);
            driveBackground();
        end
        @(negedge Clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hdl/cuPkg.sv
hdl/opcodeDecoder.sv
hdl/flagSampler.sv
hdl/stateSequencer.sv
hdl/controlWordGen.sv
hdl/controlUnit.sv
tb/clockGen.sv
tb/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module controlUnitTb \
    -o controlUnitSim
./obj_dir/controlUnitSim
